// ==== Makefile ====
# Verilator build for the TMR configuration bank and its testbench

TB_TOP := tmr_cfg_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f flist.f --top-module $(TB_TOP)

# The run passes only if the pass message shows up in the output
sim:
	verilator --binary --timing -j 0 -f flist.f --top-module $(TB_TOP) -Mdir obj_dir
	out="$$(./obj_dir/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

// ==== dv/tmr_cfg_tb.sv ====
//==========================================================================
// Self-checking testbench for the TMR configuration bank
// Random writes, reads and single-copy upsets are checked against a model
//==========================================================================

`default_nettype none

module tmr_cfg_tb;
  import tmr_cfg_pkg::*;
  import tmr_fault_pkg::*;

  // Length of each test phase
  localparam int NumRandOps  = 300;
  localparam int NumMixedInj = 40;
  localparam int NumSatInj   = 280;

  // Writes take 2 cycles, reads 1 and upsets 3, plus reset and final reads
  localparam int PlannedCycles = 20 + 2 * NumRandOps + 5 * NumMixedInj + 3 * NumSatInj;
  localparam int MaxCycles     = 2 * PlannedCycles;

  logic                 clk;
  logic                 rst_n;
  logic                 wr_en;
  logic [AddrWidth-1:0] addr;
  logic [BusWidth-1:0]  wdata;
  logic [BusWidth-1:0]  rd_data;
  logic                 inj_en;
  copy_sel_t            inj_copy;
  logic [BusWidth-1:0]  inj_mask;
  logic                 err;
  logic                 err_sticky;
  err_cnt_t             err_count;

  // The model holds the register values masked to their width and the monitor outputs
  logic [BusWidth-1:0] model [NumRegs];
  err_cnt_t            exp_count;
  logic                exp_sticky;

  logic [31:0] rng_state;
  int          num_checks;
  int          num_errors;
  int          num_effective;
  int          cycle_count;

  tmr_cfg_top tmr_cfg_top_i (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .wr_en_i      (wr_en),
    .addr_i       (addr),
    .wdata_i      (wdata),
    .rd_data_o    (rd_data),
    .inj_en_i     (inj_en),
    .inj_copy_i   (inj_copy),
    .inj_mask_i   (inj_mask),
    .err_o        (err),
    .err_sticky_o (err_sticky),
    .err_count_o  (err_count)
  );

  always #50 clk = ~clk;

  // Ends a run that never reaches its closing line
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= MaxCycles) begin
      $display("timeout: the run did not finish within %0d cycles", MaxCycles);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  // Xorshift32 step that never reaches a zero state from a nonzero seed
  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic logic [31:0] low_ones(input int unsigned n);
    return (n >= 32) ? '1 : ((32'h1 << n) - 32'h1);
  endfunction

  // Bits of the bus that the register at address a actually holds
  function automatic logic [31:0] payload_mask(input logic [AddrWidth-1:0] a);
    case (a)
      AddrCtrl:   return low_ones($bits(ctrl_t));
      AddrThresh: return low_ones($bits(thresh_t));
      AddrLimit:  return low_ones($bits(limit_t));
      default:    return low_ones($bits(scratch_t));
    endcase
  endfunction

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    num_checks = num_checks + 1;
    if (actual !== expected) begin
      num_errors = num_errors + 1;
      $display("mismatch at time %0t: %s is %h, expected %h", $time, what, actual, expected);
    end
  endtask

  // Monitor outputs against the model, with the expected live error level
  task automatic expect_status(input logic exp_err);
    check_value(32'(err), 32'(exp_err), "err_o");
    check_value(32'(err_sticky), 32'(exp_sticky), "err_sticky_o");
    check_value(32'(err_count), 32'(exp_count), "err_count_o");
  endtask

  task automatic read_reg(input logic [AddrWidth-1:0] a);
    @(posedge clk);
    addr   <= a;
    wr_en  <= 1'b0;
    inj_en <= 1'b0;
    @(negedge clk);
    check_value(rd_data, model[a], "read data");
  endtask

  task automatic write_reg(input logic [AddrWidth-1:0] a, input logic [31:0] d);
    @(posedge clk);
    addr  <= a;
    wdata <= d;
    wr_en <= 1'b1;
    @(posedge clk);
    wr_en <= 1'b0;
    model[a] = d & payload_mask(a);
    @(negedge clk);
    check_value(rd_data, model[a], "read after write");
  endtask

  // One upset, then the cycle with err_o high, then the scrub edge
  task automatic inject_upset(input logic [AddrWidth-1:0] a, input copy_sel_t c,
                              input logic [31:0] m);
    logic effective;
    effective = (c != 2'd3) && ((m & payload_mask(a)) != '0);
    @(posedge clk);
    addr     <= a;
    inj_copy <= c;
    inj_mask <= m;
    inj_en   <= 1'b1;
    wr_en    <= 1'b0;
    @(posedge clk);
    inj_en <= 1'b0;
    @(negedge clk);
    check_value(32'(err), 32'(effective), "err_o after upset");
    check_value(rd_data, model[a], "read during upset");
    if (effective) begin
      exp_sticky    = 1'b1;
      num_effective = num_effective + 1;
      if (exp_count != '1) begin
        exp_count = exp_count + err_cnt_t'(1);
      end
    end
    @(negedge clk);
    expect_status(1'b0);
    check_value(rd_data, model[a], "read after scrub");
  endtask

  initial begin
    logic [31:0]          r;
    logic [31:0]          m;
    logic [AddrWidth-1:0] a;
    clk           = 1'b0;
    rst_n         = 1'b0;
    wr_en         = 1'b0;
    addr          = '0;
    wdata         = '0;
    inj_en        = 1'b0;
    inj_copy      = 2'd3;
    inj_mask      = '0;
    rng_state     = 32'h83063dc4;
    num_checks    = 0;
    num_errors    = 0;
    num_effective = 0;
    cycle_count   = 0;
    exp_count     = '0;
    exp_sticky    = 1'b0;
    model[AddrCtrl]                    = '0;
    model[AddrCtrl][$bits(ctrl_t)-1:0] = CtrlRst;
    model[AddrThresh]                  = 32'(ThreshRst);
    model[AddrLimit]                   = 32'(LimitRst);
    model[AddrScratch]                 = 32'(ScratchRst);
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;

    // Reset values and a quiet monitor
    for (int i = 0; i < NumRegs; i++) begin
      read_reg(AddrWidth'(i));
    end
    expect_status(1'b0);

    // Random writes and reads
    for (int i = 0; i < NumRandOps; i++) begin
      r = next_random();
      a = r[1:0];
      if (r[2]) begin
        write_reg(a, next_random());
      end else begin
        read_reg(a);
      end
    end

    // Mix of effective upsets, copy 3 and masks outside the payload
    for (int i = 0; i < NumMixedInj; i++) begin
      r = next_random();
      a = r[1:0];
      m = next_random();
      if (r[5:4] == 2'd0) begin
        m = m & ~payload_mask(a);
      end
      if (r[6]) begin
        write_reg(a, next_random());
      end
      inject_upset(a, copy_sel_t'(r[3:2]), m);
    end

    // Effective upsets only, enough to drive the count into saturation
    for (int i = 0; i < NumSatInj; i++) begin
      r = next_random();
      a = r[1:0];
      m = next_random() & payload_mask(a);
      if (m == '0) begin
        m = 32'h1;
      end
      inject_upset(a, copy_sel_t'(r[7:4] % 4'd3), m);
    end
    check_value(32'(err_count), 32'({ErrCntWidth{1'b1}}), "saturated err_count_o");
    check_value(32'(err_sticky), 32'h1, "err_sticky_o after upsets");
    for (int i = 0; i < NumRegs; i++) begin
      read_reg(AddrWidth'(i));
    end

    $display("summary: %0d checks, %0d errors, %0d effective upsets",
             num_checks, num_errors, num_effective);
    if (num_errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
source/tmr_cfg_pkg.sv
source/tmr_fault_pkg.sv
source/reg_bus_if.sv
source/tmr_reg.sv
source/tmr_reg_bank.sv
source/tmr_err_monitor.sv
source/tmr_cfg_top.sv
dv/tmr_cfg_tb.sv

// ==== source/reg_bus_if.sv ====
//==========================================================================
// Write, read and fault-injection bus between the top level and the bank
//==========================================================================

`default_nettype none

interface reg_bus_if;
  import tmr_cfg_pkg::*;
  import tmr_fault_pkg::*;

  // One-cycle write strobe with its address and data
  logic                 wr_en;
  logic [AddrWidth-1:0] addr;
  logic [BusWidth-1:0]  wdata;

  // Combinational read data for the current address
  logic [BusWidth-1:0]  rdata;

  // One-cycle injection strobe, copy select and bit mask
  // The injection targets the register at addr as well
  logic                 inj_en;
  copy_sel_t            inj_copy;
  logic [BusWidth-1:0]  inj_mask;

  // The bank consumes every request and returns read data
  modport bank (
    input  wr_en, addr, wdata, inj_en, inj_copy, inj_mask,
    output rdata
  );

  // The host drives every request and samples read data
  modport host (
    output wr_en, addr, wdata, inj_en, inj_copy, inj_mask,
    input  rdata
  );

endinterface

`default_nettype wire

// ==== source/tmr_cfg_pkg.sv ====
//==========================================================================
// Register map, payload types and reset values of the TMR configuration bank
// Imported by the interface, the register bank and the top level
//==========================================================================

`default_nettype none

package tmr_cfg_pkg;

  // Host data bus and register address widths
  localparam int unsigned BusWidth  = 32;
  localparam int unsigned AddrWidth = 2;

  // One protected register per address
  localparam int unsigned NumRegs = 4;

  // Register map
  localparam logic [AddrWidth-1:0] AddrCtrl    = 2'd0;
  localparam logic [AddrWidth-1:0] AddrThresh  = 2'd1;
  localparam logic [AddrWidth-1:0] AddrLimit   = 2'd2;
  localparam logic [AddrWidth-1:0] AddrScratch = 2'd3;

  // The enable bit sits in the MSB of the control word and prescale in the low nibble
  typedef struct packed {
    logic       enable;
    logic [2:0] mode;
    logic [3:0] prescale;
  } ctrl_t;

  // Plain vector payloads of the remaining registers
  typedef logic [15:0] thresh_t;
  typedef logic [15:0] limit_t;
  typedef logic [31:0] scratch_t;

  // Reset values are nonzero so a missed reset shows up on readback
  localparam ctrl_t    CtrlRst    = 8'h15;
  localparam thresh_t  ThreshRst  = 16'h0100;
  localparam limit_t   LimitRst   = 16'hFF00;
  localparam scratch_t ScratchRst = 32'hC0FFEE00;

endpackage

`default_nettype wire

// ==== source/tmr_cfg_top.sv ====
//==========================================================================
// Top level of the TMR configuration bank
// Maps the plain host ports onto the bus and joins the bank to the monitor
//==========================================================================

`default_nettype none

module tmr_cfg_top (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  logic                                wr_en_i,
  input  logic [tmr_cfg_pkg::AddrWidth-1:0]   addr_i,
  input  logic [tmr_cfg_pkg::BusWidth-1:0]    wdata_i,
  output logic [tmr_cfg_pkg::BusWidth-1:0]    rd_data_o,
  input  logic                                inj_en_i,
  input  tmr_fault_pkg::copy_sel_t            inj_copy_i,
  input  logic [tmr_cfg_pkg::BusWidth-1:0]    inj_mask_i,
  output logic                                err_o,
  output logic                                err_sticky_o,
  output tmr_fault_pkg::err_cnt_t             err_count_o
);
  import tmr_cfg_pkg::*;

  // Per-register disagreement flags from the bank
  logic [NumRegs-1:0] err_vec;

  // Host side of the bus is fed straight from the ports
  reg_bus_if bus ();

  assign bus.wr_en    = wr_en_i;
  assign bus.addr     = addr_i;
  assign bus.wdata    = wdata_i;
  assign bus.inj_en   = inj_en_i;
  assign bus.inj_copy = inj_copy_i;
  assign bus.inj_mask = inj_mask_i;

  // Read data is combinational from addr_i through the bank
  assign rd_data_o = bus.rdata;

  // Protected registers
  tmr_reg_bank u_bank (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .bus       (bus),
    .err_vec_o (err_vec)
  );

  // Error level, sticky flag and count
  tmr_err_monitor u_monitor (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .err_vec_i    (err_vec),
    .err_o        (err_o),
    .err_sticky_o (err_sticky_o),
    .err_count_o  (err_count_o)
  );

endmodule

`default_nettype wire

// ==== source/tmr_err_monitor.sv ====
//==========================================================================
// Error monitor for the TMR bank
// Gives a live error level, a sticky flag and a saturating error-cycle count
//==========================================================================

`default_nettype none

module tmr_err_monitor (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  logic [tmr_cfg_pkg::NumRegs-1:0] err_vec_i,
  output logic                            err_o,
  output logic                            err_sticky_o,
  output tmr_fault_pkg::err_cnt_t         err_count_o
);
  import tmr_fault_pkg::*;

  // Sticky flag and error-cycle counter
  logic     sticky_q;
  err_cnt_t count_q;

  // The live error level is high while any register has a disagreement
  assign err_o = |err_vec_i;

  // Set on the first error and held until the next reset
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sticky_q <= 1'b0;
    end else if (err_o) begin
      sticky_q <= 1'b1;
    end
  end

  // Counts cycles with an error rather than erroneous registers
  // Two registers upset in one cycle add only one
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      count_q <= '0;
    end else if (err_o && (count_q != '1)) begin
      count_q <= count_q + err_cnt_t'(1);
    end
  end

  assign err_sticky_o = sticky_q;
  assign err_count_o  = count_q;

endmodule

`default_nettype wire

// ==== source/tmr_fault_pkg.sv ====
//==========================================================================
// Types and constants of fault injection and error counting
//==========================================================================

`default_nettype none

package tmr_fault_pkg;

  // Index of the copy to upset
  // Values 0 to 2 pick one of the three copies, 3 picks none
  typedef logic [1:0] copy_sel_t;

  // Width of the saturating error-cycle counter
  localparam int unsigned ErrCntWidth = 8;

  // The counter holds at all ones once it is full
  typedef logic [ErrCntWidth-1:0] err_cnt_t;

endpackage

`default_nettype wire

// ==== source/tmr_reg.sv ====
//==========================================================================
// One triplicated register with load, fault injection, scrubbing and voter
// The payload type sets the width and each register gets its own instance
//==========================================================================

`default_nettype none

module tmr_reg #(
  parameter type payload_t = logic [7:0]
) (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     load_i,
  input  payload_t                 data_i,
  input  payload_t                 reset_value_i,
  input  logic                     inj_en_i,
  input  tmr_fault_pkg::copy_sel_t inj_copy_i,
  input  payload_t                 inj_mask_i,
  output payload_t                 data_o,
  output logic                     err_o
);
  import tmr_fault_pkg::*;

  // Three redundant copies of the payload
  payload_t copy_q [3];

  // Pairwise differences used by the voter
  logic [$bits(payload_t)-1:0] diff_ab;
  logic [$bits(payload_t)-1:0] diff_bc;

  // Set where copy C must be taken instead of copy A
  logic [$bits(payload_t)-1:0] sel;

  // A bit that differs only between A and B has a faulty A or B
  // If B and C agree there, A is the odd one out and C is taken
  // If B also differs from C, B is the odd one and A is taken
  // Where A and B agree, A already holds the majority
  assign diff_ab = copy_q[0] ^ copy_q[1];
  assign diff_bc = copy_q[1] ^ copy_q[2];
  assign sel     = diff_ab & ~diff_bc;

  assign data_o = payload_t'((copy_q[0] & ~sel) | (copy_q[2] & sel));

  // Any difference at all means one copy has been upset
  assign err_o = |(diff_ab | diff_bc);

  // Priority is reset, then load, then scrub, then injection
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int unsigned i = 0; i < 3; i++) begin
        copy_q[i] <= reset_value_i;
      end
    end else if (load_i) begin
      // A write replaces all three copies and wins over any pending upset
      for (int unsigned i = 0; i < 3; i++) begin
        copy_q[i] <= data_i;
      end
    end else if (err_o) begin
      // Scrub by writing the voted value back into every copy
      for (int unsigned i = 0; i < 3; i++) begin
        copy_q[i] <= data_o;
      end
    end else if (inj_en_i) begin
      // Only the selected copy is flipped and select value 3 matches none
      for (int unsigned i = 0; i < 3; i++) begin
        if (inj_copy_i == copy_sel_t'(i)) begin
          copy_q[i] <= payload_t'(copy_q[i] ^ inj_mask_i);
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/tmr_reg_bank.sv ====
//==========================================================================
// Bank of four TMR registers with address decode and read multiplexing
// Returns one disagreement flag per register for the error monitor
//==========================================================================

`default_nettype none

module tmr_reg_bank (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  reg_bus_if.bank                          bus,
  output logic [tmr_cfg_pkg::NumRegs-1:0]  err_vec_o
);
  import tmr_cfg_pkg::*;

  // One-hot load and injection strobes indexed by register address
  logic [NumRegs-1:0] load;
  logic [NumRegs-1:0] inj;

  // Voted value of each register
  ctrl_t    ctrl_val;
  thresh_t  thresh_val;
  limit_t   limit_val;
  scratch_t scratch_val;

  // Both strobes act on the register selected by addr
  assign load = bus.wr_en  ? (NumRegs'(1) << bus.addr) : '0;
  assign inj  = bus.inj_en ? (NumRegs'(1) << bus.addr) : '0;

  // Control register
  tmr_reg #(
    .payload_t (ctrl_t)
  ) u_ctrl (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .load_i        (load[AddrCtrl]),
    .data_i        (ctrl_t'(bus.wdata[$bits(ctrl_t)-1:0])),
    .reset_value_i (CtrlRst),
    .inj_en_i      (inj[AddrCtrl]),
    .inj_copy_i    (bus.inj_copy),
    .inj_mask_i    (ctrl_t'(bus.inj_mask[$bits(ctrl_t)-1:0])),
    .data_o        (ctrl_val),
    .err_o         (err_vec_o[AddrCtrl])
  );

  // Threshold register
  tmr_reg #(
    .payload_t (thresh_t)
  ) u_thresh (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .load_i        (load[AddrThresh]),
    .data_i        (bus.wdata[$bits(thresh_t)-1:0]),
    .reset_value_i (ThreshRst),
    .inj_en_i      (inj[AddrThresh]),
    .inj_copy_i    (bus.inj_copy),
    .inj_mask_i    (bus.inj_mask[$bits(thresh_t)-1:0]),
    .data_o        (thresh_val),
    .err_o         (err_vec_o[AddrThresh])
  );

  // Limit register
  tmr_reg #(
    .payload_t (limit_t)
  ) u_limit (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .load_i        (load[AddrLimit]),
    .data_i        (bus.wdata[$bits(limit_t)-1:0]),
    .reset_value_i (LimitRst),
    .inj_en_i      (inj[AddrLimit]),
    .inj_copy_i    (bus.inj_copy),
    .inj_mask_i    (bus.inj_mask[$bits(limit_t)-1:0]),
    .data_o        (limit_val),
    .err_o         (err_vec_o[AddrLimit])
  );

  // Scratch register spans the full bus width
  tmr_reg #(
    .payload_t (scratch_t)
  ) u_scratch (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .load_i        (load[AddrScratch]),
    .data_i        (bus.wdata),
    .reset_value_i (ScratchRst),
    .inj_en_i      (inj[AddrScratch]),
    .inj_copy_i    (bus.inj_copy),
    .inj_mask_i    (bus.inj_mask),
    .data_o        (scratch_val),
    .err_o         (err_vec_o[AddrScratch])
  );

  // Reads return the voted value, zero-extended to the bus width
  always_comb begin
    bus.rdata = '0;
    case (bus.addr)
      AddrCtrl:    bus.rdata[$bits(ctrl_t)-1:0]   = ctrl_val;
      AddrThresh:  bus.rdata[$bits(thresh_t)-1:0] = thresh_val;
      AddrLimit:   bus.rdata[$bits(limit_t)-1:0]  = limit_val;
      default:     bus.rdata                      = scratch_val;
    endcase
  end

endmodule

`default_nettype wire
